// ==== lsu_pkg.sv ====
package lsu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [3:0]  byte_mask_t;    // One bit per byte lane
    typedef logic [11:0] imm_t;          // Signed I-type immediate
    typedef logic [5:0]  tag_t;          // Physical destination register

    typedef enum logic [2:0] {
        LB,
        LH,
        LW,
        LBU,
        LHU
    } load_op_e;

    typedef enum logic [1:0] {
        WAITING_INPUT,
        WAITING_SQ,
        WAITING_MEM,
        WAITING_OUTPUT
    } load_state_e;

    typedef struct packed {
        word_t    base;
        imm_t     imm;
        load_op_e op;
        tag_t     dest_tag;
    } load_issue_t;

    // Word aligned address plus the lanes the load reads
    typedef struct packed {
        word_t      word_addr;
        byte_mask_t need_mask;
    } sq_lookup_t;

    typedef struct packed {
        logic       stall;       // Older matching store still lacks data
        byte_mask_t fwd_mask;
        word_t      fwd_data;
    } sq_result_t;

    typedef struct packed {
        tag_t  dest_tag;
        word_t value;
    } load_result_t;

    // Store leaving the queue for memory
    typedef struct packed {
        word_t      word_addr;
        byte_mask_t mask;
        word_t      data;
    } store_write_t;

endpackage

// ==== load_addr_gen.sv ====
module load_addr_gen (
    input  lsu_pkg::load_issue_t issue,
    output lsu_pkg::word_t       addr,
    output lsu_pkg::byte_mask_t  need_mask
);
    import lsu_pkg::*;

    word_t imm_ext;

    assign imm_ext = {{20{issue.imm[11]}}, issue.imm};
    assign addr    = issue.base + imm_ext;

    // Misaligned halfword or word leaves the mask empty
    always_comb begin
        need_mask = '0;
        case (issue.op)
            LB, LBU: begin
                need_mask = 4'b0001 << addr[1:0];
            end
            LH, LHU: begin
                if (!addr[0]) begin
                    need_mask = addr[1] ? 4'b1100 : 4'b0011;
                end
            end
            LW: begin
                if (addr[1:0] == 2'b00) begin
                    need_mask = 4'b1111;
                end
            end
            default: begin
                need_mask = '0;
            end
        endcase
    end

endmodule

// ==== load_control.sv ====
module load_control (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 issue_valid,
    input  lsu_pkg::load_issue_t issue,
    input  lsu_pkg::word_t       addr,
    input  lsu_pkg::byte_mask_t  need_mask,
    output logic                 issue_ready,
    output logic                 load_accept,
    output lsu_pkg::sq_lookup_t  lookup,
    input  lsu_pkg::sq_result_t  sq_result,
    output logic                 mem_read,
    output lsu_pkg::word_t       mem_addr,
    input  lsu_pkg::word_t       merged_value,
    output lsu_pkg::load_op_e    align_op,
    output logic [1:0]           align_offset,
    output lsu_pkg::byte_mask_t  align_fwd_mask,
    output lsu_pkg::word_t       align_fwd_data,
    input  logic                 complete_stall,
    output logic                 complete_valid,
    output lsu_pkg::load_result_t complete
);
    import lsu_pkg::*;

    // In-flight load
    typedef struct packed {
        word_t      addr;
        byte_mask_t need;
        load_op_e   op;
        tag_t       tag;
        byte_mask_t fwd_mask;
        word_t      fwd_data;
        word_t      value;
    } load_rec_t;

    load_state_e state;
    load_rec_t   rec;
    logic        full_fwd;
    word_t       word_addr;

    assign word_addr   = {rec.addr[31:2], 2'b00};
    assign full_fwd    = (sq_result.fwd_mask & rec.need) == rec.need;
    assign issue_ready = state == WAITING_INPUT;
    assign load_accept = issue_valid && issue_ready;

    assign lookup.word_addr = word_addr;
    assign lookup.need_mask = rec.need;

    assign mem_read = state == WAITING_SQ && !sq_result.stall && !full_fwd;
    assign mem_addr = word_addr;

    // Live forward answer while in the lookup state, captured copy after
    always_comb begin
        if (state == WAITING_SQ) begin
            align_fwd_mask = full_fwd ? 4'b1111 : sq_result.fwd_mask;
            align_fwd_data = sq_result.fwd_data;
        end else begin
            align_fwd_mask = rec.fwd_mask;
            align_fwd_data = rec.fwd_data;
        end
    end

    assign align_op     = rec.op;
    assign align_offset = rec.addr[1:0];

    assign complete_valid    = state == WAITING_OUTPUT;
    assign complete.dest_tag = rec.tag;
    assign complete.value    = rec.value;

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= WAITING_INPUT;
        end else begin
            case (state)
                WAITING_INPUT: begin
                    if (issue_valid) state <= WAITING_SQ;
                end
                WAITING_SQ: begin
                    if (!sq_result.stall) state <= full_fwd ? WAITING_OUTPUT : WAITING_MEM;
                end
                WAITING_MEM: begin
                    state <= WAITING_OUTPUT;
                end
                WAITING_OUTPUT: begin
                    if (!complete_stall) state <= WAITING_INPUT;
                end
                default: begin
                    state <= WAITING_INPUT;
                end
            endcase
        end
    end

    always_ff @(posedge clock) begin
        case (state)
            WAITING_INPUT: begin
                rec.addr     <= addr;
                rec.need     <= need_mask;
                rec.op       <= issue.op;
                rec.tag      <= issue.dest_tag;
                rec.fwd_mask <= '0;
            end
            WAITING_SQ: begin
                rec.fwd_mask <= sq_result.fwd_mask;
                rec.fwd_data <= sq_result.fwd_data;
                if (full_fwd) rec.value <= merged_value;   // Memory never read
            end
            WAITING_MEM: begin
                rec.value <= merged_value;
            end
            default: begin
                rec <= rec;   // Held under complete_stall
            end
        endcase
    end

    a_issue_when_ready: assert property (@(posedge clock) disable iff (reset)
        issue_valid |-> issue_ready)
        else $error("issue_valid while not ready");

    a_aligned_load: assert property (@(posedge clock) disable iff (reset)
        issue_valid |-> need_mask != '0)
        else $error("misaligned load issued");

endmodule

// ==== store_queue.sv ====
module store_queue #(
    parameter int SQ_DEPTH = 8
) (
    input  logic                          clock,
    input  logic                          reset,
    input  logic                          store_alloc,
    input  lsu_pkg::word_t                store_addr,
    input  lsu_pkg::byte_mask_t           store_mask,
    input  logic                          store_data_valid,
    input  logic [$clog2(SQ_DEPTH)-1:0]   store_index,
    input  lsu_pkg::word_t                store_data,
    input  logic                          store_commit,
    input  logic                          load_accept,
    input  lsu_pkg::sq_lookup_t           lookup,
    output lsu_pkg::sq_result_t           sq_result,
    output logic                          mem_write,
    output lsu_pkg::store_write_t         mem_write_req,
    output logic                          sq_full,
    output logic [$clog2(SQ_DEPTH)-1:0]   sq_tail
);
    import lsu_pkg::*;

    localparam int IDX_W = $clog2(SQ_DEPTH);

    // Pointers carry one wrap bit
    logic [IDX_W:0] head;
    logic [IDX_W:0] tail;
    logic [IDX_W:0] snap_tail;
    logic [IDX_W:0] scan_count;
    logic           sq_empty;

    word_t         addr_q [SQ_DEPTH];
    byte_mask_t    mask_q [SQ_DEPTH];
    word_t         data_q [SQ_DEPTH];
    logic [SQ_DEPTH-1:0] data_ok;

    assign sq_empty   = head == tail;
    assign sq_full    = (tail - head) == (IDX_W + 1)'(SQ_DEPTH);
    assign sq_tail    = tail[IDX_W-1:0];
    assign scan_count = snap_tail - head;   // Stores older than the load

    always_ff @(posedge clock) begin
        if (reset) begin
            head      <= '0;
            tail      <= '0;
            snap_tail <= '0;
            data_ok   <= '0;
        end else begin
            if (store_alloc) begin
                tail                   <= tail + 1'b1;
                data_ok[tail[IDX_W-1:0]] <= 1'b0;
            end
            if (store_data_valid) data_ok[store_index] <= 1'b1;
            if (store_commit) head <= head + 1'b1;
            if (load_accept) snap_tail <= tail;
        end
    end

    always_ff @(posedge clock) begin
        if (store_alloc) begin
            addr_q[tail[IDX_W-1:0]] <= {store_addr[31:2], 2'b00};
            mask_q[tail[IDX_W-1:0]] <= store_mask;
        end
        if (store_data_valid) data_q[store_index] <= store_data;
    end

    // Oldest to youngest, so later matches overwrite earlier ones
    always_comb begin
        logic [IDX_W-1:0] idx;
        byte_mask_t       hit;
        sq_result = '0;
        for (int k = 0; k < SQ_DEPTH; k++) begin
            idx = head[IDX_W-1:0] + IDX_W'(k);
            hit = mask_q[idx] & lookup.need_mask;
            if (k < scan_count && scan_count <= SQ_DEPTH
                    && addr_q[idx] == lookup.word_addr && hit != '0) begin
                if (!data_ok[idx]) sq_result.stall = 1'b1;
                for (int b = 0; b < 4; b++) begin
                    if (hit[b]) begin
                        sq_result.fwd_mask[b]          = 1'b1;
                        sq_result.fwd_data[8*b +: 8] = data_q[idx][8*b +: 8];
                    end
                end
            end
        end
    end

    assign mem_write               = store_commit;
    assign mem_write_req.word_addr = addr_q[head[IDX_W-1:0]];
    assign mem_write_req.mask      = mask_q[head[IDX_W-1:0]];
    assign mem_write_req.data      = data_q[head[IDX_W-1:0]];

    a_alloc_not_full: assert property (@(posedge clock) disable iff (reset)
        store_alloc |-> !sq_full)
        else $error("store allocated into full queue");

    a_commit_not_empty: assert property (@(posedge clock) disable iff (reset)
        store_commit |-> !sq_empty)
        else $error("commit from empty queue");

    a_commit_has_data: assert property (@(posedge clock) disable iff (reset)
        store_commit |-> data_ok[head[IDX_W-1:0]])
        else $error("commit of store without data");

endmodule

// ==== data_mem.sv ====
module data_mem #(
    parameter int MEM_WORDS = 256
) (
    input  logic                  clock,
    input  logic                  mem_read,
    input  lsu_pkg::word_t        mem_addr,
    output lsu_pkg::word_t        mem_data,
    input  logic                  mem_write,
    input  lsu_pkg::store_write_t mem_write_req
);
    import lsu_pkg::*;

    localparam int AW = $clog2(MEM_WORDS);

    word_t mem [MEM_WORDS];

    initial begin
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    // Read returns the word as it was before a same-edge write
    always_ff @(posedge clock) begin
        if (mem_read) mem_data <= mem[mem_addr[AW+1:2]];
    end

    always_ff @(posedge clock) begin
        if (mem_write) begin
            for (int b = 0; b < 4; b++) begin
                if (mem_write_req.mask[b]) begin
                    mem[mem_write_req.word_addr[AW+1:2]][8*b +: 8] <= mem_write_req.data[8*b +: 8];
                end
            end
        end
    end

endmodule

// ==== load_align.sv ====
module load_align (
    input  lsu_pkg::word_t      mem_data,
    input  lsu_pkg::byte_mask_t align_fwd_mask,
    input  lsu_pkg::word_t      align_fwd_data,
    input  lsu_pkg::load_op_e   align_op,
    input  logic [1:0]          align_offset,
    output lsu_pkg::word_t      merged_value
);
    import lsu_pkg::*;

    word_t merged;
    word_t shifted;

    // Forwarded lanes win over memory
    always_comb begin
        merged = mem_data;
        for (int b = 0; b < 4; b++) begin
            if (align_fwd_mask[b]) merged[8*b +: 8] = align_fwd_data[8*b +: 8];
        end
    end

    assign shifted = merged >> {align_offset, 3'b000};   // Wanted bytes to lane 0

    always_comb begin
        case (align_op)
            LB: begin
                merged_value = {{24{shifted[7]}}, shifted[7:0]};
            end
            LBU: begin
                merged_value = {24'b0, shifted[7:0]};
            end
            LH: begin
                merged_value = {{16{shifted[15]}}, shifted[15:0]};
            end
            LHU: begin
                merged_value = {16'b0, shifted[15:0]};
            end
            LW: begin
                merged_value = merged;
            end
            default: begin
                merged_value = merged;
            end
        endcase
    end

endmodule

// ==== load_unit_top.sv ====
module load_unit_top #(
    parameter int SQ_DEPTH  = 8,
    parameter int MEM_WORDS = 256
) (
    input  logic                          clock,
    input  logic                          reset,
    input  logic                          issue_valid,
    input  lsu_pkg::load_issue_t          issue,
    output logic                          issue_ready,
    input  logic                          store_alloc,
    input  lsu_pkg::word_t                store_addr,
    input  lsu_pkg::byte_mask_t           store_mask,
    input  logic                          store_data_valid,
    input  logic [$clog2(SQ_DEPTH)-1:0]   store_index,
    input  lsu_pkg::word_t                store_data,
    input  logic                          store_commit,
    input  logic                          complete_stall,
    output logic                          complete_valid,
    output lsu_pkg::load_result_t         complete,
    output logic                          sq_full,
    output logic [$clog2(SQ_DEPTH)-1:0]   sq_tail
);
    import lsu_pkg::*;

    word_t        addr;
    byte_mask_t   need_mask;
    logic         load_accept;
    sq_lookup_t   lookup;
    sq_result_t   sq_result;
    logic         mem_read;
    word_t        mem_addr;
    word_t        mem_data;
    logic         mem_write;
    store_write_t mem_write_req;
    word_t        merged_value;
    load_op_e     align_op;
    logic [1:0]   align_offset;
    byte_mask_t   align_fwd_mask;
    word_t        align_fwd_data;

    load_addr_gen load_addr_gen_inst (
        .issue     (issue),
        .addr      (addr),
        .need_mask (need_mask)
    );

    load_control load_control_inst (
        .clock          (clock),
        .reset          (reset),
        .issue_valid    (issue_valid),
        .issue          (issue),
        .addr           (addr),
        .need_mask      (need_mask),
        .issue_ready    (issue_ready),
        .load_accept    (load_accept),
        .lookup         (lookup),
        .sq_result      (sq_result),
        .mem_read       (mem_read),
        .mem_addr       (mem_addr),
        .merged_value   (merged_value),
        .align_op       (align_op),
        .align_offset   (align_offset),
        .align_fwd_mask (align_fwd_mask),
        .align_fwd_data (align_fwd_data),
        .complete_stall (complete_stall),
        .complete_valid (complete_valid),
        .complete       (complete)
    );

    store_queue #(
        .SQ_DEPTH (SQ_DEPTH)
    ) store_queue_inst (
        .clock            (clock),
        .reset            (reset),
        .store_alloc      (store_alloc),
        .store_addr       (store_addr),
        .store_mask       (store_mask),
        .store_data_valid (store_data_valid),
        .store_index      (store_index),
        .store_data       (store_data),
        .store_commit     (store_commit),
        .load_accept      (load_accept),
        .lookup           (lookup),
        .sq_result        (sq_result),
        .mem_write        (mem_write),
        .mem_write_req    (mem_write_req),
        .sq_full          (sq_full),
        .sq_tail          (sq_tail)
    );

    data_mem #(
        .MEM_WORDS (MEM_WORDS)
    ) data_mem_inst (
        .clock         (clock),
        .mem_read      (mem_read),
        .mem_addr      (mem_addr),
        .mem_data      (mem_data),
        .mem_write     (mem_write),
        .mem_write_req (mem_write_req)
    );

    load_align load_align_inst (
        .mem_data       (mem_data),
        .align_fwd_mask (align_fwd_mask),
        .align_fwd_data (align_fwd_data),
        .align_op       (align_op),
        .align_offset   (align_offset),
        .merged_value   (merged_value)
    );

endmodule

// ==== tb_load_unit.sv ====
module tb_load_unit;
    import lsu_pkg::*;

    localparam int SQ_DEPTH    = 8;
    localparam int IDX_W       = $clog2(SQ_DEPTH);
    localparam int CYCLE_LIMIT = 4000;

    logic             clock;
    logic             reset;
    logic             issue_valid;
    load_issue_t      issue;
    logic             issue_ready;
    logic             store_alloc;
    word_t            store_addr;
    byte_mask_t       store_mask;
    logic             store_data_valid;
    logic [IDX_W-1:0] store_index;
    word_t            store_data;
    logic             store_commit;
    logic             complete_stall;
    logic             complete_valid;
    load_result_t     complete;
    logic             sq_full;
    logic [IDX_W-1:0] sq_tail;

    // Reference memory, and stores indexed by allocation count
    word_t        ref_mem [256];
    word_t        model_addr [128];
    byte_mask_t   model_mask [128];
    word_t        model_data [128];
    int           model_head;
    int           model_count;

    string        test_name;
    int           cycle_count = 0;
    word_t        load_addr;
    load_op_e     load_op;
    tag_t         load_tag;
    int           load_snap;    // Stores older than the current load
    logic         load_pending;
    logic         data_pending;
    load_result_t exp_result;

    load_unit_top #(
        .SQ_DEPTH  (SQ_DEPTH),
        .MEM_WORDS (256)
    ) load_unit_top_inst (
        .clock            (clock),
        .reset            (reset),
        .issue_valid      (issue_valid),
        .issue            (issue),
        .issue_ready      (issue_ready),
        .store_alloc      (store_alloc),
        .store_addr       (store_addr),
        .store_mask       (store_mask),
        .store_data_valid (store_data_valid),
        .store_index      (store_index),
        .store_data       (store_data),
        .store_commit     (store_commit),
        .complete_stall   (complete_stall),
        .complete_valid   (complete_valid),
        .complete         (complete),
        .sq_full          (sq_full),
        .sq_tail          (sq_tail)
    );

    always #5 clock = ~clock;

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("run did not finish within %0d cycles, last test %s", CYCLE_LIMIT, test_name);
            stop_with_failure();
        end
    end

    task automatic stop_with_failure();
        $display("TEST FAIL");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string what, input logic [63:0] expected,
                                   input logic [63:0] actual);
        $display("error %s %s expected %0h actual %0h", test_name, what, expected, actual);
        stop_with_failure();
    endtask

    task automatic report_failure(input string what);
        $display("%s: %s", test_name, what);
        stop_with_failure();
    endtask

    result_matches: assert property (@(posedge clock) disable iff (reset)
        complete_valid |-> complete == exp_result)
        else report_mismatch("complete", $sampled(exp_result), $sampled(complete));

    completion_expected: assert property (@(posedge clock) disable iff (reset)
        complete_valid |-> load_pending && !data_pending)
        else report_failure("completion without a load that could finish");

    held_under_stall: assert property (@(posedge clock) disable iff (reset)
        complete_valid && complete_stall |=> complete_valid && $stable(complete))
        else report_failure("completion dropped or changed while stalled");

    busy_while_completing: assert property (@(posedge clock) disable iff (reset)
        complete_valid |-> !issue_ready)
        else report_failure("issue_ready high during completion");

    ready_after_retire: assert property (@(posedge clock) disable iff (reset)
        complete_valid && !complete_stall |=> issue_ready)
        else report_failure("issue_ready low after completion was taken");

    // Model counters move after the edge, as the queue pointers do
    tail_matches: assert property (@(posedge clock) disable iff (reset)
        sq_tail == IDX_W'(model_count % SQ_DEPTH))
        else report_mismatch("sq_tail", $sampled(model_count) % SQ_DEPTH, $sampled(sq_tail));

    full_matches: assert property (@(posedge clock) disable iff (reset)
        sq_full == (model_count - model_head == SQ_DEPTH))
        else report_mismatch("sq_full", $sampled(model_count - model_head == SQ_DEPTH),
                             $sampled(sq_full));

    // Youngest older store wins each byte, then extract and extend
    function automatic word_t predict_load(input word_t addr, input load_op_e op, input int snap);
        word_t w;
        word_t s;
        w = ref_mem[addr[9:2]];
        for (int i = model_head; i < snap; i++) begin
            if (model_addr[i] == {addr[31:2], 2'b00}) begin
                for (int b = 0; b < 4; b++) begin
                    if (model_mask[i][b]) w[8*b +: 8] = model_data[i][8*b +: 8];
                end
            end
        end
        s = w >> {addr[1:0], 3'b000};
        case (op)
            LB:      predict_load = {{24{s[7]}}, s[7:0]};
            LBU:     predict_load = {24'b0, s[7:0]};
            LH:      predict_load = {{16{s[15]}}, s[15:0]};
            LHU:     predict_load = {16'b0, s[15:0]};
            default: predict_load = w;
        endcase
    endfunction

    task automatic refresh_expected();
        exp_result.dest_tag = load_tag;
        exp_result.value    = predict_load(load_addr, load_op, load_snap);
    endtask

    task automatic next_cycle();
        @(posedge clock);
        #1;
    endtask

    task automatic alloc_store(input word_t addr, input byte_mask_t mask);
        store_alloc = 1'b1;
        store_addr  = addr;
        store_mask  = mask;
        model_addr[model_count] = {addr[31:2], 2'b00};
        model_mask[model_count] = mask;
        next_cycle();
        store_alloc = 1'b0;
        model_count++;
    endtask

    task automatic write_store_data(input int entry, input word_t data);
        store_data_valid  = 1'b1;
        store_index       = IDX_W'(entry % SQ_DEPTH);
        store_data        = data;
        model_data[entry] = data;
        if (load_pending) refresh_expected();
        next_cycle();
        store_data_valid = 1'b0;
    endtask

    task automatic commit_store();
        store_commit = 1'b1;
        for (int b = 0; b < 4; b++) begin
            if (model_mask[model_head][b]) begin
                ref_mem[model_addr[model_head][9:2]][8*b +: 8] = model_data[model_head][8*b +: 8];
            end
        end
        next_cycle();
        store_commit = 1'b0;
        model_head++;
    endtask

    task automatic issue_load(input word_t addr, input load_op_e op, input int hold);
        imm_t        imm;
        load_issue_t req;
        imm = imm_t'($urandom);
        while (!issue_ready) next_cycle();
        req.imm      = imm;
        req.base     = addr - {{20{imm[11]}}, imm};   // Base plus immediate lands on addr
        req.op       = op;
        req.dest_tag = tag_t'($urandom);
        load_addr    = addr;
        load_op      = op;
        load_tag     = req.dest_tag;
        load_snap    = model_count;
        load_pending = 1'b1;
        refresh_expected();
        complete_stall = hold > 0;
        issue          = req;
        issue_valid    = 1'b1;
        next_cycle();
        issue_valid = 1'b0;
    endtask

    task automatic finish_load(input int hold);
        while (!complete_valid) next_cycle();
        repeat (hold) begin
            next_cycle();
        end
        complete_stall = 1'b0;
        next_cycle();
        load_pending = 1'b0;
    endtask

    task automatic check_load(input word_t addr, input load_op_e op, input int hold);
        issue_load(addr, op, hold);
        finish_load(hold);
    endtask

    initial begin
        int first;
        void'($urandom(32'h95b882ae));
        clock            = 1'b0;
        reset            = 1'b1;
        issue_valid      = 1'b0;
        issue            = '0;
        store_alloc      = 1'b0;
        store_addr       = '0;
        store_mask       = '0;
        store_data_valid = 1'b0;
        store_index      = '0;
        store_data       = '0;
        store_commit     = 1'b0;
        complete_stall   = 1'b0;
        load_pending     = 1'b0;
        data_pending     = 1'b0;
        exp_result       = '0;
        model_head       = 0;
        model_count      = 0;
        test_name        = "reset";
        for (int i = 0; i < 256; i++) ref_mem[i] = '0;
        repeat (8) @(posedge clock);
        #1;
        reset = 1'b0;
        assert (issue_ready && !complete_valid) else report_failure("unit not idle after reset");

        test_name = "memory_loads";
        repeat (16) begin
            alloc_store(32'h200 + 4 * ($urandom % 8), byte_mask_t'(1 + $urandom % 15));
            write_store_data(model_count - 1, $urandom);
            commit_store();
        end
        for (int w = 0; w < 8; w++) begin
            for (int off = 0; off < 4; off++) begin
                check_load(32'h200 + 4 * w + off, LB, 0);
                check_load(32'h200 + 4 * w + off, LBU, 0);
                if (!off[0]) begin
                    check_load(32'h200 + 4 * w + off, LH, 0);
                    check_load(32'h200 + 4 * w + off, LHU, 0);
                end
                if (off == 0) check_load(32'h200 + 4 * w, LW, 0);
            end
        end

        test_name = "full_forward";
        first = model_count;
        alloc_store(32'h300, 4'b1111);
        alloc_store(32'h300, 4'b0110);    // Younger, overrides the middle lanes
        write_store_data(first + 1, $urandom);
        write_store_data(first, $urandom);
        check_load(32'h300, LW, 0);
        check_load(32'h302, LH, 0);
        check_load(32'h301, LBU, 0);
        check_load(32'h303, LB, 0);
        commit_store();
        commit_store();

        test_name = "partial_forward";
        alloc_store(32'h208, 4'b0001);
        write_store_data(model_count - 1, $urandom);
        check_load(32'h208, LW, 0);
        check_load(32'h208, LH, 0);
        check_load(32'h20a, LHU, 0);
        check_load(32'h208, LB, 0);
        commit_store();

        test_name = "data_wait";
        first = model_count;
        alloc_store(32'h310, 4'b1100);
        data_pending = 1'b1;
        issue_load(32'h312, LHU, 0);
        alloc_store(32'h310, 4'b1111);    // After acceptance, so not seen by the load
        write_store_data(first + 1, $urandom);
        repeat (5) begin
            next_cycle();
            assert (!complete_valid) else report_failure("load finished before its store data");
        end
        write_store_data(first, $urandom);
        data_pending = 1'b0;
        finish_load(0);
        commit_store();
        commit_store();

        test_name = "complete_stall";
        check_load(32'h204, LW, 6);
        alloc_store(32'h320, 4'b1111);
        write_store_data(model_count - 1, $urandom);
        check_load(32'h322, LH, 4);
        commit_store();

        test_name = "queue_full";
        first = model_count;
        for (int i = 0; i < SQ_DEPTH; i++) begin
            alloc_store(32'h340 + 4 * i, 4'b1111);
        end
        for (int i = 0; i < SQ_DEPTH; i++) begin
            write_store_data(first + i, $urandom);
        end
        check_load(32'h35c, LW, 0);       // Youngest entry of a full queue
        check_load(32'h340, LHU, 0);
        repeat (SQ_DEPTH) begin
            commit_store();
        end

        $display("TEST PASS");
        $finish;
    end

endmodule

// ==== sim.f ====
lsu_pkg.sv
load_addr_gen.sv
load_control.sv
store_queue.sv
data_mem.sv
load_align.sv
load_unit_top.sv
tb_load_unit.sv
